// ==== compile.f ====
hdl/rec_pkg.sv
hdl/rec_cmd_ctrl.sv
hdl/rec_reg_file.sv
hdl/rec_resp_streamer.sv
hdl/rec_executor.sv
dv/rec_properties.sv
dv/rec_tb.sv

// ==== Makefile ====
# Verilator build and run for the recovery executor testbench

VERILATOR ?= verilator
TOP       ?= rec_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= PASS: all tests

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/rec_tb.sv ====
`timescale 1ns/1ns
// Testbench for the recovery executor with command source, RX queue and stall models
module rec_tb;

  localparam int unsigned FifoDepth = 64;
  localparam int unsigned Timeout   = 2000;
  localparam int unsigned FifoWords = 70;
  // Identification text in the order it goes out on the wire
  localparam logic [63:0] MagicText = "OCP RECV";

  logic                          clk_i;
  logic                          rst_ni;
  logic                          cmd_valid_i;
  rec_pkg::rec_cmd_t             cmd_i;
  logic                          recovery_mode_i;
  logic                          host_abort_i;
  logic                          rx_rack_i;
  logic [rec_pkg::WordWidth-1:0] rx_rdata_i;
  logic                          indirect_wready_i;
  logic                          indirect_full_i;
  logic                          indirect_empty_i;
  logic                          res_ready_i;
  logic                          res_dready_i;
  logic                          cmd_done_o;
  logic                          rx_rreq_o;
  logic                          indirect_wvalid_o;
  logic [rec_pkg::WordWidth-1:0] indirect_wdata_o;
  logic                          indirect_clr_o;
  logic                          rx_queue_clr_o;
  logic                          res_valid_o;
  logic [15:0]                   res_len_o;
  logic                          res_dvalid_o;
  logic [7:0]                    res_data_o;
  logic                          res_dlast_o;
  logic                          payload_available_o;
  logic                          image_activated_o;

  int          seed = 2;
  int          done_cycles;
  int          clr_cycles;
  int          rreq_cycles;
  logic [31:0] rx_words[$];
  logic [31:0] fifo_exp[$];
  logic [7:0]  rd_bytes[$];
  logic        rd_last[$];
  logic [15:0] hdr_len[$];
  logic [7:0]  reject_ops [4] = '{8'd33, 8'd48, 8'd40, 8'd38};

  rec_executor #(
    .IndirectFifoDepth (FifoDepth)
  ) uut (.*);

  bind rec_executor rec_properties props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_done_i   (cmd_done_o),
    .rx_rreq_i    (rx_rreq_o),
    .res_dvalid_i (res_dvalid_o),
    .res_dready_i (res_dready_i),
    .res_data_i   (res_data_o)
  );

  task automatic fail_run(input string msg);
    $display("%0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error %0t: %s got %0h expected %0h", $time, name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Random ready stalls on the response and indirect FIFO ports
  initial begin
    res_ready_i       = 1'b0;
    res_dready_i      = 1'b0;
    indirect_wready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      res_ready_i       = ($random(seed) & 3) != 0;
      res_dready_i      = ($random(seed) & 3) != 0;
      indirect_wready_i = ($random(seed) & 3) != 0;
    end
  end

  // RX queue answers each request after zero to three idle cycles
  initial begin : rx_queue_model
    int delay;
    rx_rack_i  = 1'b0;
    rx_rdata_i = '0;
    forever begin
      @(negedge clk_i);
      if (rx_rreq_o) begin
        @(posedge clk_i);
        #2;
        delay = $random(seed) & 3;
        repeat (delay) begin
          @(posedge clk_i);
          #2;
        end
        if (rx_words.size() == 0) fail_run("RX request with no word left in the queue");
        rx_rack_i  = 1'b1;
        rx_rdata_i = rx_words.pop_front();
        @(posedge clk_i);
        #2;
        rx_rack_i = 1'b0;
      end
    end
  end

  // Transfers are sampled mid-cycle before the edge that completes them
  always @(negedge clk_i) begin
    if (res_valid_o && res_ready_i) hdr_len.push_back(res_len_o);
    if (res_dvalid_o && res_dready_i) begin
      rd_bytes.push_back(res_data_o);
      rd_last.push_back(res_dlast_o);
    end
    if (indirect_wvalid_o) begin
      if (fifo_exp.size() == 0) fail_run("indirect FIFO write with no word expected");
      check_value("indirect_wdata_o", indirect_wdata_o, fifo_exp.pop_front());
    end
    if (rx_rreq_o) rreq_cycles++;
    if (rx_queue_clr_o) clr_cycles++;
    if (uut.props.err_count != 0) fail_run("a bound protocol assertion failed");
  end

  task automatic run_cmd(input logic is_rd, input logic [7:0] op, input logic [15:0] len,
                         input logic crc);
    int cycles;
    rd_bytes.delete();
    rd_last.delete();
    hdr_len.delete();
    clr_cycles  = 0;
    rreq_cycles = 0;
    cmd_i = '{is_rd: is_rd, opcode: rec_pkg::rec_cmd_e'(op), len: len, crc_err: crc};
    cmd_valid_i = 1'b1;
    @(posedge clk_i);
    #2;
    cmd_valid_i = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) fail_run("timeout waiting for cmd_done_o");
    end while (!cmd_done_o);
    done_cycles = cycles;
    @(posedge clk_i);
    #2;
  endtask

  task automatic read_cmd(input logic [7:0] op, input int exp_len);
    run_cmd(1'b1, op, 16'd0, 1'b0);
    if (hdr_len.size() != 1) fail_run("response header missing or repeated");
    check_value("res_len_o", 32'(hdr_len[0]), exp_len);
    check_value("res_dvalid_o transfers", rd_bytes.size(), exp_len);
    for (int i = 0; i < exp_len; i++) begin
      check_value("res_dlast_o", 32'(rd_last[i]), 32'(i == exp_len - 1));
    end
  endtask

  function automatic logic [31:0] status_word(input int w);
    return {rd_bytes[4*w+3], rd_bytes[4*w+2], rd_bytes[4*w+1], rd_bytes[4*w]};
  endfunction

  initial begin
    logic [31:0] word;
    logic [7:0]  exp_byte;
    rst_ni           = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_i            = '0;
    recovery_mode_i  = 1'b1;
    host_abort_i     = 1'b0;
    indirect_full_i  = 1'b0;
    indirect_empty_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #2;

    // Each rejection is followed by a status read and the last one is CRC flagged
    for (int i = 0; i < 4; i++) begin
      recovery_mode_i = (i != 2);
      run_cmd(1'b0, reject_ops[i], 16'd4, i == 3);
      recovery_mode_i = 1'b1;
      check_value("cmd_done_o delay", done_cycles, 2);
      check_value("rx_queue_clr_o cycles", clr_cycles, 1);
      check_value("rx_rreq_o cycles", rreq_cycles, 0);
      read_cmd(8'd36, 8);
      check_value("DEVICE_STATUS byte 1", 32'(rd_bytes[1]), (i == 3) ? 4 : 2);
    end

    read_cmd(8'd34, 15);
    for (int i = 0; i < 15; i++) begin
      if (i < 8) exp_byte = MagicText[8*(7-i) +: 8];
      else if (i < 12) exp_byte = rec_pkg::PROT_VERSION_WORD[8*(i-8) +: 8];
      else exp_byte = 8'h00;
      check_value("res_data_o", 32'(rd_bytes[i]), 32'(exp_byte));
    end

    // Activation byte set on the first pass only
    for (int k = 0; k < 2; k++) begin
      word = $random(seed);
      if (k == 0) word[23:16] = 8'h0F;
      else if (word[23:16] == 8'h0F) word[23:16] = 8'h10;
      rx_words.push_back(word);
      run_cmd(1'b0, 8'd38, 16'd3, 1'b0);
      check_value("image_activated_o", 32'(image_activated_o), 32'(k == 0));
      read_cmd(8'd38, 3);
      for (int i = 0; i < 3; i++) begin
        check_value("res_data_o", 32'(rd_bytes[i]), 32'(word[8*i +: 8]));
      end
    end

    // Odd byte count rounds up to whole words and wraps the write index
    for (int i = 0; i < FifoWords; i++) begin
      word = $random(seed);
      rx_words.push_back(word);
      fifo_exp.push_back(word);
    end
    run_cmd(1'b0, 8'd47, 16'(4 * FifoWords - 1), 1'b0);
    check_value("pending indirect words", fifo_exp.size(), 0);
    check_value("payload_available_o", 32'(payload_available_o), 1);
    read_cmd(8'd46, 20);
    check_value("FIFO_STATUS_1", status_word(1), FifoWords % FifoDepth);
    check_value("FIFO_STATUS_3", status_word(3), FifoDepth);

    word = $random(seed);
    word[15:8] = 8'd1;
    rx_words.push_back(word);
    rx_words.push_back($random(seed));
    run_cmd(1'b0, 8'd45, 16'd6, 1'b0);
    check_value("indirect_clr_o", 32'(indirect_clr_o), 1);
    check_value("payload_available_o", 32'(payload_available_o), 0);
    read_cmd(8'd46, 20);
    check_value("FIFO_STATUS_1", status_word(1), 0);
    check_value("unused RX words", rx_words.size(), 0);

    if (uut.props.err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      fail_run("a bound protocol assertion failed");
    end
  end

endmodule

// ==== dv/rec_properties.sv ====
`timescale 1ns/1ns
// Protocol assertions bound to the recovery executor top level
module rec_properties (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       cmd_valid_i,
  input logic       cmd_done_i,
  input logic       rx_rreq_i,
  input logic       res_dvalid_i,
  input logic       res_dready_i,
  input logic [7:0] res_data_i
);

  int   err_count = 0;
  logic busy_q;

  // Command in flight from acceptance until its done pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (cmd_done_i) begin
      busy_q <= 1'b0;
    end else if (cmd_valid_i) begin
      busy_q <= 1'b1;
    end
  end

  // Done is a single-cycle pulse per command
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_done_i |=> !cmd_done_i)
    else begin
      $error("cmd_done_o stayed high for more than one cycle");
      err_count++;
    end

  // A stalled byte must not change or disappear
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   res_dvalid_i && !res_dready_i |=> res_dvalid_i && $stable(res_data_i))
    else begin
      $error("res_dvalid_o or res_data_o changed while res_dready_i was low");
      err_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !busy_q |-> !rx_rreq_i)
    else begin
      $error("rx_rreq_o high while no command is in flight");
      err_count++;
    end

  // Each request is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) rx_rreq_i |=> !rx_rreq_i)
    else begin
      $error("rx_rreq_o held for more than one cycle");
      err_count++;
    end

endmodule

// ==== hdl/rec_executor.sv ====
`timescale 1ns/1ns
// Recovery command executor top joining control, register file and response streamer
module rec_executor #(
  parameter int unsigned IndirectFifoDepth = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cmd_valid_i,
  input  rec_pkg::rec_cmd_t             cmd_i,
  input  logic                          recovery_mode_i,
  input  logic                          host_abort_i,
  input  logic                          rx_rack_i,
  input  logic [rec_pkg::WordWidth-1:0] rx_rdata_i,
  input  logic                          indirect_wready_i,
  input  logic                          indirect_full_i,
  input  logic                          indirect_empty_i,
  input  logic                          res_ready_i,
  input  logic                          res_dready_i,
  output logic                          cmd_done_o,
  output logic                          rx_rreq_o,
  output logic                          indirect_wvalid_o,
  output logic [rec_pkg::WordWidth-1:0] indirect_wdata_o,
  output logic                          indirect_clr_o,
  output logic                          rx_queue_clr_o,
  output logic                          res_valid_o,
  output logic [15:0]                   res_len_o,
  output logic                          res_dvalid_o,
  output logic [7:0]                    res_data_o,
  output logic                          res_dlast_o,
  output logic                          payload_available_o,
  output logic                          image_activated_o
);

  rec_pkg::rec_reg_wr_t          reg_wr;
  rec_pkg::rec_rd_req_t          rd_req;
  rec_pkg::rec_prot_e            prot_status;
  rec_pkg::rec_reg_e             rd_idx;
  logic [rec_pkg::WordWidth-1:0] rd_word;
  logic                          fifo_push;
  logic                          prot_we;
  logic                          payload_set;
  logic                          rd_done;

  rec_cmd_ctrl u_cmd_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cmd_valid_i       (cmd_valid_i),
    .cmd_i             (cmd_i),
    .recovery_mode_i   (recovery_mode_i),
    .host_abort_i      (host_abort_i),
    .rx_rack_i         (rx_rack_i),
    .rx_rdata_i        (rx_rdata_i),
    .indirect_wready_i (indirect_wready_i),
    .rd_done_i         (rd_done),
    .cmd_done_o        (cmd_done_o),
    .rx_rreq_o         (rx_rreq_o),
    .indirect_wvalid_o (indirect_wvalid_o),
    .indirect_wdata_o  (indirect_wdata_o),
    .rx_queue_clr_o    (rx_queue_clr_o),
    .reg_wr_o          (reg_wr),
    .fifo_push_o       (fifo_push),
    .prot_status_o     (prot_status),
    .prot_we_o         (prot_we),
    .payload_set_o     (payload_set),
    .rd_req_o          (rd_req)
  );

  rec_reg_file #(
    .IndirectFifoDepth (IndirectFifoDepth)
  ) u_reg_file (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .reg_wr_i            (reg_wr),
    .fifo_push_i         (fifo_push),
    .prot_status_i       (prot_status),
    .prot_we_i           (prot_we),
    .payload_set_i       (payload_set),
    .indirect_full_i     (indirect_full_i),
    .indirect_empty_i    (indirect_empty_i),
    .rd_idx_i            (rd_idx),
    .rd_word_o           (rd_word),
    .indirect_clr_o      (indirect_clr_o),
    .payload_available_o (payload_available_o),
    .image_activated_o   (image_activated_o)
  );

  rec_resp_streamer u_resp_streamer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_req_i     (rd_req),
    .res_ready_i  (res_ready_i),
    .res_dready_i (res_dready_i),
    .host_abort_i (host_abort_i),
    .rd_word_i    (rd_word),
    .rd_idx_o     (rd_idx),
    .rd_done_o    (rd_done),
    .res_valid_o  (res_valid_o),
    .res_len_o    (res_len_o),
    .res_dvalid_o (res_dvalid_o),
    .res_data_o   (res_data_o),
    .res_dlast_o  (res_dlast_o)
  );

endmodule

// ==== hdl/rec_resp_streamer.sv ====
`timescale 1ns/1ns
// Read response streamer that sends the length header and then register bytes
module rec_resp_streamer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  rec_pkg::rec_rd_req_t          rd_req_i,
  input  logic                          res_ready_i,
  input  logic                          res_dready_i,
  input  logic                          host_abort_i,
  input  logic [rec_pkg::WordWidth-1:0] rd_word_i,
  output rec_pkg::rec_reg_e             rd_idx_o,
  output logic                          rd_done_o,
  output logic                          res_valid_o,
  output logic [15:0]                   res_len_o,
  output logic                          res_dvalid_o,
  output logic [7:0]                    res_data_o,
  output logic                          res_dlast_o
);

  logic              hdr_q;
  logic              data_q;
  logic [15:0]       rem_q;
  logic [1:0]        lane_q;
  rec_pkg::rec_reg_e idx_q;
  logic              hdr_take;
  logic              byte_take;

  assign hdr_take  = hdr_q && res_ready_i;
  assign byte_take = data_q && res_dready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_q  <= 1'b0;
      data_q <= 1'b0;
      rem_q  <= '0;
      lane_q <= '0;
      idx_q  <= rec_pkg::REG_NONE;
    end else if (rd_req_i.start) begin
      hdr_q  <= 1'b1;
      rem_q  <= rd_req_i.len;
      lane_q <= '0;
      idx_q  <= rd_req_i.first_reg;
    end else if (host_abort_i) begin
      hdr_q  <= 1'b0;
      data_q <= 1'b0;
    end else if (hdr_take) begin
      hdr_q  <= 1'b0;
      data_q <= rem_q != '0;
    end else if (byte_take) begin
      rem_q  <= rem_q - 16'd1;
      lane_q <= lane_q + 2'd1;
      // Next register word after its top byte
      if (lane_q == 2'd3) idx_q <= rec_pkg::rec_reg_e'(idx_q + 5'd1);
      if (rem_q == 16'd1) data_q <= 1'b0;
    end
  end

  // rem_q still holds the full length while the header is up
  assign res_valid_o  = hdr_q;
  assign res_len_o    = rem_q;
  assign res_dvalid_o = data_q;
  assign res_data_o   = rd_word_i[{lane_q, 3'b000} +: 8];
  assign res_dlast_o  = data_q && (rem_q == 16'd1);
  assign rd_idx_o     = idx_q;

  assign rd_done_o = !host_abort_i &&
                     ((byte_take && res_dlast_o) || (hdr_take && rem_q == '0));

endmodule

// ==== hdl/rec_reg_file.sv ====
`timescale 1ns/1ns
// Recovery register file holding control words, FIFO write index and status flags
module rec_reg_file #(
  parameter int unsigned IndirectFifoDepth = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  rec_pkg::rec_reg_wr_t          reg_wr_i,
  input  logic                          fifo_push_i,
  input  rec_pkg::rec_prot_e            prot_status_i,
  input  logic                          prot_we_i,
  input  logic                          payload_set_i,
  input  logic                          indirect_full_i,
  input  logic                          indirect_empty_i,
  input  rec_pkg::rec_reg_e             rd_idx_i,
  output logic [rec_pkg::WordWidth-1:0] rd_word_o,
  output logic                          indirect_clr_o,
  output logic                          payload_available_o,
  output logic                          image_activated_o
);

  localparam int unsigned IdxWidth = $clog2(IndirectFifoDepth);

  logic [23:0]         device_reset_q;
  logic [23:0]         recovery_ctrl_q;
  logic [31:0]         fifo_ctrl_0_q;
  logic [15:0]         fifo_ctrl_1_q;
  rec_pkg::rec_prot_e  prot_q;
  logic [IdxWidth-1:0] wr_idx_q;
  logic                payload_q;
  logic                fifo_clr;

  // Reset request sits in byte 1 of FIFO_CTRL_0
  assign fifo_clr = fifo_ctrl_0_q[15:8] == 8'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_q  <= '0;
      recovery_ctrl_q <= '0;
      fifo_ctrl_0_q   <= '0;
      fifo_ctrl_1_q   <= '0;
      prot_q          <= rec_pkg::PROT_OK;
    end else begin
      if (reg_wr_i.we) begin
        case (reg_wr_i.idx)
          rec_pkg::REG_DEVICE_RESET:  device_reset_q  <= reg_wr_i.data[23:0];
          rec_pkg::REG_RECOVERY_CTRL: recovery_ctrl_q <= reg_wr_i.data[23:0];
          rec_pkg::REG_FIFO_CTRL_0:   fifo_ctrl_0_q   <= reg_wr_i.data;
          rec_pkg::REG_FIFO_CTRL_1:   fifo_ctrl_1_q   <= reg_wr_i.data[15:0];
          default: ;
        endcase
      end
      if (prot_we_i) prot_q <= prot_status_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q  <= '0;
      payload_q <= 1'b0;
    end else begin
      if (fifo_clr) wr_idx_q <= '0;
      else if (fifo_push_i) begin
        if (wr_idx_q == IdxWidth'(IndirectFifoDepth - 1)) wr_idx_q <= '0;
        else wr_idx_q <= wr_idx_q + 1'b1;
      end

      if (fifo_clr) payload_q <= 1'b0;
      else if (payload_set_i) payload_q <= 1'b1;
    end
  end

  assign indirect_clr_o      = fifo_clr;
  assign payload_available_o = payload_q;
  assign image_activated_o   = recovery_ctrl_q[23:16] == 8'h0F;

  // Combinational read port for the response streamer
  always_comb begin
    case (rd_idx_i)
      rec_pkg::REG_PROT_CAP_0:      rd_word_o = rec_pkg::PROT_MAGIC_0;
      rec_pkg::REG_PROT_CAP_1:      rd_word_o = rec_pkg::PROT_MAGIC_1;
      rec_pkg::REG_PROT_CAP_2:      rd_word_o = rec_pkg::PROT_VERSION_WORD;
      rec_pkg::REG_DEVICE_STATUS_0: rd_word_o = {16'd0, prot_q, 8'd0};
      rec_pkg::REG_DEVICE_RESET:    rd_word_o = {8'd0, device_reset_q};
      rec_pkg::REG_RECOVERY_CTRL:   rd_word_o = {8'd0, recovery_ctrl_q};
      rec_pkg::REG_FIFO_CTRL_0:     rd_word_o = fifo_ctrl_0_q;
      rec_pkg::REG_FIFO_CTRL_1:     rd_word_o = {16'd0, fifo_ctrl_1_q};
      rec_pkg::REG_FIFO_STATUS_0:   rd_word_o = {30'd0, indirect_full_i, indirect_empty_i};
      rec_pkg::REG_FIFO_STATUS_1:   rd_word_o = 32'(wr_idx_q);
      rec_pkg::REG_FIFO_STATUS_3:   rd_word_o = 32'(IndirectFifoDepth);
      // PROT_CAP_3, DEVICE_STATUS_1, read index and max transfer read as zero
      default:                      rd_word_o = '0;
    endcase
  end

endmodule

// ==== hdl/rec_cmd_ctrl.sv ====
`timescale 1ns/1ns
// Recovery command controller that validates commands and runs the write transfers
module rec_cmd_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cmd_valid_i,
  input  rec_pkg::rec_cmd_t             cmd_i,
  input  logic                          recovery_mode_i,
  input  logic                          host_abort_i,
  input  logic                          rx_rack_i,
  input  logic [rec_pkg::WordWidth-1:0] rx_rdata_i,
  input  logic                          indirect_wready_i,
  input  logic                          rd_done_i,
  output logic                          cmd_done_o,
  output logic                          rx_rreq_o,
  output logic                          indirect_wvalid_o,
  output logic [rec_pkg::WordWidth-1:0] indirect_wdata_o,
  output logic                          rx_queue_clr_o,
  output rec_pkg::rec_reg_wr_t          reg_wr_o,
  output logic                          fifo_push_o,
  output rec_pkg::rec_prot_e            prot_status_o,
  output logic                          prot_we_o,
  output logic                          payload_set_o,
  output rec_pkg::rec_rd_req_t          rd_req_o
);

  rec_pkg::rec_state_e state_q;
  rec_pkg::rec_state_e state_d;
  rec_pkg::rec_prot_e  prot_q;
  rec_pkg::rec_prot_e  prot_check;
  rec_pkg::rec_reg_e   reg_idx_q;
  logic [15:0]         words_q;
  logic                pending_q;
  logic                reg_over_q;
  logic                accept;
  logic                legal_op;
  logic                mode_block;
  logic                reject;
  logic                in_write;
  logic                fifo_cmd;

  assign accept   = (state_q == rec_pkg::ST_IDLE) && cmd_valid_i;
  assign fifo_cmd = cmd_i.opcode == rec_pkg::CMD_INDIRECT_FIFO_DATA;
  assign in_write = (state_q == rec_pkg::ST_REG_WRITE) || (state_q == rec_pkg::ST_FIFO_WRITE);

  // Opcodes served here, everything else is a parameter error
  assign legal_op = cmd_i.opcode inside {rec_pkg::CMD_PROT_CAP, rec_pkg::CMD_DEVICE_STATUS,
                                         rec_pkg::CMD_DEVICE_RESET, rec_pkg::CMD_RECOVERY_CTRL,
                                         rec_pkg::CMD_INDIRECT_FIFO_CTRL,
                                         rec_pkg::CMD_INDIRECT_FIFO_STATUS,
                                         rec_pkg::CMD_INDIRECT_FIFO_DATA};
  assign mode_block = !recovery_mode_i && (cmd_i.opcode > 8'd39);

  always_comb begin
    if (cmd_i.crc_err) prot_check = rec_pkg::PROT_CRC;
    else if (!legal_op || mode_block) prot_check = rec_pkg::PROT_PARAMETER;
    else prot_check = rec_pkg::PROT_OK;
  end

  assign reject = prot_check != rec_pkg::PROT_OK;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rec_pkg::ST_IDLE: begin
        if (cmd_valid_i) begin
          if (reject) state_d = rec_pkg::ST_ERROR;
          else if (cmd_i.is_rd) state_d = rec_pkg::ST_READ;
          else if (fifo_cmd) state_d = rec_pkg::ST_FIFO_WRITE;
          else state_d = rec_pkg::ST_REG_WRITE;
        end
      end
      rec_pkg::ST_REG_WRITE, rec_pkg::ST_FIFO_WRITE: begin
        // Zero-length writes fall straight through
        if (words_q == '0 || (rx_rack_i && words_q == 16'd1)) state_d = rec_pkg::ST_DONE;
      end
      rec_pkg::ST_READ: begin
        if (host_abort_i) state_d = rec_pkg::ST_ERROR;
        else if (rd_done_i) state_d = rec_pkg::ST_DONE;
      end
      rec_pkg::ST_ERROR: state_d = rec_pkg::ST_DONE;
      default:           state_d = rec_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= rec_pkg::ST_IDLE;
      prot_q     <= rec_pkg::PROT_OK;
      reg_idx_q  <= rec_pkg::REG_NONE;
      words_q    <= '0;
      pending_q  <= 1'b0;
      reg_over_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= (pending_q || rx_rreq_o) && !rx_rack_i;
      if (accept) begin
        prot_q     <= prot_check;
        reg_idx_q  <= rec_pkg::cmd_first_reg(cmd_i.opcode);
        words_q    <= {2'b00, cmd_i.len[15:2]} + 16'(|cmd_i.len[1:0]);
        reg_over_q <= 1'b0;
      end else if (in_write && rx_rack_i) begin
        words_q <= words_q - 16'd1;
        // Hold at the block end and drop any surplus words
        if (reg_idx_q == rec_pkg::cmd_last_reg(cmd_i.opcode)) reg_over_q <= 1'b1;
        else reg_idx_q <= rec_pkg::rec_reg_e'(reg_idx_q + 5'd1);
      end
    end
  end

  // One outstanding RX request, FIFO writes also wait for a ready FIFO
  assign rx_rreq_o = in_write && !pending_q && (words_q != '0) &&
                     ((state_q == rec_pkg::ST_REG_WRITE) || indirect_wready_i);

  assign fifo_push_o       = (state_q == rec_pkg::ST_FIFO_WRITE) && rx_rack_i;
  assign indirect_wvalid_o = fifo_push_o;
  assign indirect_wdata_o  = rx_rdata_i;

  assign reg_wr_o = '{idx:  reg_idx_q,
                      data: rx_rdata_i,
                      we:   (state_q == rec_pkg::ST_REG_WRITE) && rx_rack_i && !reg_over_q};

  assign rd_req_o = '{first_reg: rec_pkg::cmd_first_reg(cmd_i.opcode),
                      len:       rec_pkg::cmd_byte_len(cmd_i.opcode),
                      start:     accept && !reject && cmd_i.is_rd};

  assign payload_set_o  = accept && !reject && !cmd_i.is_rd && fifo_cmd;
  assign prot_status_o  = prot_q;
  assign prot_we_o      = state_q == rec_pkg::ST_DONE;
  assign cmd_done_o     = state_q == rec_pkg::ST_DONE;
  assign rx_queue_clr_o = state_q == rec_pkg::ST_ERROR;

endmodule

// ==== hdl/rec_pkg.sv ====
// Recovery executor package with opcodes, register map, status codes and shared types
package rec_pkg;

  localparam int unsigned WordWidth = 32;

  typedef enum logic [7:0] {
    CMD_PROT_CAP             = 8'd34,
    CMD_DEVICE_ID            = 8'd35,
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_RECOVERY_STATUS      = 8'd39,
    CMD_HW_STATUS            = 8'd40,
    CMD_INDIRECT_CTRL        = 8'd41,
    CMD_INDIRECT_STATUS      = 8'd42,
    CMD_INDIRECT_DATA        = 8'd43,
    CMD_VENDOR               = 8'd44,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } rec_cmd_e;

  typedef enum logic [4:0] {
    REG_PROT_CAP_0      = 5'd0,
    REG_PROT_CAP_1      = 5'd1,
    REG_PROT_CAP_2      = 5'd2,
    REG_PROT_CAP_3      = 5'd3,
    REG_DEVICE_STATUS_0 = 5'd4,
    REG_DEVICE_STATUS_1 = 5'd5,
    REG_DEVICE_RESET    = 5'd6,
    REG_RECOVERY_CTRL   = 5'd7,
    REG_FIFO_CTRL_0     = 5'd8,
    REG_FIFO_CTRL_1     = 5'd9,
    REG_FIFO_STATUS_0   = 5'd10,
    REG_FIFO_STATUS_1   = 5'd11,
    REG_FIFO_STATUS_2   = 5'd12,
    REG_FIFO_STATUS_3   = 5'd13,
    REG_FIFO_STATUS_4   = 5'd14,
    REG_NONE            = 5'd31
  } rec_reg_e;

  typedef enum logic [7:0] {
    PROT_OK        = 8'd0,
    PROT_PARAMETER = 8'd2,
    PROT_CRC       = 8'd4
  } rec_prot_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REG_WRITE,
    ST_FIFO_WRITE,
    ST_READ,
    ST_ERROR,
    ST_DONE
  } rec_state_e;

  typedef struct packed {
    logic        is_rd;
    rec_cmd_e    opcode;
    logic [15:0] len;
    logic        crc_err;
  } rec_cmd_t;

  typedef struct packed {
    rec_reg_e    first_reg;
    logic [15:0] len;
    logic        start;
  } rec_rd_req_t;

  typedef struct packed {
    rec_reg_e               idx;
    logic [WordWidth-1:0]   data;
    logic                   we;
  } rec_reg_wr_t;

  // Byte 0 goes out first, so "OCP " and "RECV" sit LSB first
  localparam logic [WordWidth-1:0] PROT_MAGIC_0      = 32'h2050_434F;
  localparam logic [WordWidth-1:0] PROT_MAGIC_1      = 32'h5643_4552;
  // Major and minor version in the low bytes, no agent capabilities
  localparam logic [WordWidth-1:0] PROT_VERSION_WORD = 32'h0000_0101;

  function automatic rec_reg_e cmd_first_reg(rec_cmd_e op);
    case (op)
      CMD_PROT_CAP:             return REG_PROT_CAP_0;
      CMD_DEVICE_STATUS:        return REG_DEVICE_STATUS_0;
      CMD_DEVICE_RESET:         return REG_DEVICE_RESET;
      CMD_RECOVERY_CTRL:        return REG_RECOVERY_CTRL;
      CMD_INDIRECT_FIFO_CTRL:   return REG_FIFO_CTRL_0;
      CMD_INDIRECT_FIFO_STATUS: return REG_FIFO_STATUS_0;
      default:                  return REG_NONE;
    endcase
  endfunction

  function automatic rec_reg_e cmd_last_reg(rec_cmd_e op);
    case (op)
      CMD_PROT_CAP:             return REG_PROT_CAP_3;
      CMD_DEVICE_STATUS:        return REG_DEVICE_STATUS_1;
      CMD_DEVICE_RESET:         return REG_DEVICE_RESET;
      CMD_RECOVERY_CTRL:        return REG_RECOVERY_CTRL;
      CMD_INDIRECT_FIFO_CTRL:   return REG_FIFO_CTRL_1;
      CMD_INDIRECT_FIFO_STATUS: return REG_FIFO_STATUS_4;
      default:                  return REG_NONE;
    endcase
  endfunction

  function automatic logic [15:0] cmd_byte_len(rec_cmd_e op);
    case (op)
      CMD_PROT_CAP:             return 16'd15;
      CMD_DEVICE_STATUS:        return 16'd8;
      CMD_DEVICE_RESET:         return 16'd3;
      CMD_RECOVERY_CTRL:        return 16'd3;
      CMD_INDIRECT_FIFO_CTRL:   return 16'd6;
      CMD_INDIRECT_FIFO_STATUS: return 16'd20;
      default:                  return 16'd0;
    endcase
  endfunction

endpackage
